/* source/fp_mul_pkg.sv */
`default_nettype none

package fp_mul_pkg;

	// binary32 format
	localparam int exp_w    = 8;
	localparam int frac_w   = 23;
	localparam int exp_bias = 127;
	localparam int exp_max  = 255;                  // All-ones exponent, inf and NaN

	localparam int mag_w      = exp_w + frac_w;     // Word without the sign bit
	localparam int mant_w     = frac_w + 1;         // Significand with hidden bit
	localparam int prod_w     = 2 * mant_w;         // Full significand product
	localparam int lz_w       = 6;                  // Holds shift counts up to 47
	localparam int exp_calc_w = 11;                 // Signed exponent working width

	// Magnitude pattern of infinity, anything above it is a NaN
	localparam logic [mag_w-1:0] mag_inf = {{exp_w{1'b1}}, {frac_w{1'b0}}};

	typedef struct packed {
		logic              sign;
		logic [exp_w-1:0]  exp;
		logic [frac_w-1:0] frac;
	} fp32_t;

	// Same 32 bits seen as fields or as a raw word
	typedef union packed {
		fp32_t       f;
		logic [31:0] raw;
	} fp32_u;

	typedef enum logic [1:0] {
		kind_none = 2'd0,   // Regular operands, take the datapath result
		kind_nan  = 2'd1,
		kind_inf  = 2'd2,
		kind_zero = 2'd3
	} special_kind_t;

	// Classifier output, 35 bits
	typedef struct packed {
		special_kind_t kind;
		logic          sign;   // Sign of an inf or zero result
		fp32_u         word;   // NaN passed through with payload
	} fp_class_t;

	typedef enum logic [1:0] {
		in_range  = 2'd0,
		overflow  = 2'd1,
		underflow = 2'd2
	} range_t;

	// Datapath output, 34 bits
	typedef struct packed {
		logic              sign;
		logic [exp_w-1:0]  exp;
		logic [frac_w-1:0] frac;
		range_t            range;
	} fp_prod_t;

endpackage

`default_nettype wire

/* source/fp_classify.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_classify (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  fp_mul_pkg::fp32_u     a,
	input  fp_mul_pkg::fp32_u     b,
	output fp_mul_pkg::fp_class_t cls,
	output logic                  cls_valid
);

	import fp_mul_pkg::*;

	logic [mag_w-1:0] mag_a;   // Magnitudes, sign stripped
	logic [mag_w-1:0] mag_b;
	logic             nan_a;
	logic             nan_b;
	logic             inf_a;
	logic             inf_b;
	logic             zero_a;
	logic             zero_b;
	fp_class_t        cls_next;

	assign mag_a = a.raw[mag_w-1:0];
	assign mag_b = b.raw[mag_w-1:0];

	// Exponent all ones with a nonzero fraction sits above the inf pattern
	assign nan_a  = mag_a > mag_inf;
	assign nan_b  = mag_b > mag_inf;
	assign inf_a  = mag_a == mag_inf;
	assign inf_b  = mag_b == mag_inf;
	assign zero_a = mag_a == '0;   // Signed zeros both count
	assign zero_b = mag_b == '0;

	// Priority chain, NaN first, then inf, then zero
	// so inf times zero ends up as inf
	always_comb begin
		cls_next = '0;
		if (nan_a) begin
			cls_next.kind = kind_nan;
			cls_next.word = a;                 // Keep a's payload
		end
		else if (nan_b) begin
			cls_next.kind = kind_nan;
			cls_next.word = b;
		end
		else if (inf_a) begin
			cls_next.kind = kind_inf;
			cls_next.sign = a.f.sign;          // Sign of the inf operand only
		end
		else if (inf_b) begin
			cls_next.kind = kind_inf;
			cls_next.sign = b.f.sign;
		end
		else if (zero_a || zero_b) begin
			cls_next.kind = kind_zero;
			cls_next.sign = a.f.sign ^ b.f.sign;
		end
		else begin
			cls_next.kind = kind_none;         // Datapath result is used
		end
	end

	// First pipeline stage, class and strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cls       <= '0;
			cls_valid <= 1'b0;
		end
		else begin
			cls       <= cls_next;
			cls_valid <= in_valid;
		end
	end

endmodule

`default_nettype wire

/* source/fp_mant_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mant_mul (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fp_mul_pkg::fp32_u    a,
	input  fp_mul_pkg::fp32_u    b,
	output fp_mul_pkg::fp_prod_t prod
);

	import fp_mul_pkg::*;

	logic                         sign_p;
	logic                         sub_a;     // Exponent field 0, subnormal
	logic                         sub_b;
	logic [exp_w-1:0]             exp_a;     // Effective exponents
	logic [exp_w-1:0]             exp_b;
	logic [mant_w-1:0]            mant_a;    // Significands with hidden bit
	logic [mant_w-1:0]            mant_b;
	logic [prod_w-1:0]            p;         // Raw significand product
	logic signed [exp_calc_w-1:0] exp_sum;
	logic [lz_w-1:0]              lz;        // Leading zeros below bit 47
	logic [prod_w-1:0]            norm;      // Bit 46 is the hidden bit after this
	logic signed [exp_calc_w-1:0] exp_norm;
	fp_prod_t                     prod_next;

	assign sign_p = a.f.sign ^ b.f.sign;

	// Subnormal: exponent counts as 1 and the hidden bit is 0
	assign sub_a  = a.f.exp == '0;
	assign sub_b  = b.f.exp == '0;
	assign exp_a  = sub_a ? exp_w'(1) : a.f.exp;
	assign exp_b  = sub_b ? exp_w'(1) : b.f.exp;
	assign mant_a = {~sub_a, a.f.frac};
	assign mant_b = {~sub_b, b.f.frac};

	assign p = mant_a * mant_b;   // 24 x 24 -> 48

	// Biased sum, wide and signed so range checks see the true value
	assign exp_sum = $signed({{(exp_calc_w - exp_w){1'b0}}, exp_a})
		+ $signed({{(exp_calc_w - exp_w){1'b0}}, exp_b})
		- exp_calc_w'(exp_bias);

	// Leading-zero count over bits 46..0
	// Upward scan so the highest set bit wins, 47 when all clear
	always_comb begin
		lz = lz_w'(prod_w - 1);
		for (int i = 0; i < prod_w - 1; i++) begin
			if (p[i]) begin
				lz = lz_w'(prod_w - 2 - i);
			end
		end
	end

	// Normalize so the leading one sits at bit 46
	always_comb begin
		if (p[prod_w-1]) begin
			norm     = p >> 1;                   // Product in [2,4)
			exp_norm = exp_sum + exp_calc_w'(1);
		end
		else begin
			norm     = p << lz;                  // Covers subnormal operands too
			exp_norm = exp_sum - $signed({{(exp_calc_w - lz_w){1'b0}}, lz});
		end
	end

	// Assemble fields and check the range
	always_comb begin
		prod_next.sign = sign_p;
		prod_next.exp  = exp_norm[exp_w-1:0];
		prod_next.frac = norm[prod_w-3 -: frac_w];   // Bits 45..23, truncated
		if (exp_norm >= exp_calc_w'(exp_max)) begin
			prod_next.range = overflow;
		end
		else if (exp_norm <= exp_calc_w'(0)) begin
			prod_next.range = underflow;               // Flushes to zero later
		end
		else begin
			prod_next.range = in_range;
		end
	end

	// Runs every cycle, the selector qualifies with the class strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod <= '0;
		end
		else begin
			prod <= prod_next;
		end
	end

endmodule

`default_nettype wire

/* source/fp_result_select.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_result_select (
	input  logic                  clk,
	input  logic                  rst_n,
	input  fp_mul_pkg::fp_class_t cls,
	input  logic                  cls_valid,
	input  fp_mul_pkg::fp_prod_t  prod,
	output logic                  out_valid,
	output fp_mul_pkg::fp32_u     result
);

	import fp_mul_pkg::*;

	fp32_u sel_word;

	// Special class first, then datapath range, then the plain product
	always_comb begin
		sel_word = '0;
		if (cls.kind == kind_nan) begin
			sel_word = cls.word;                   // Payload unchanged
		end
		else if (cls.kind == kind_inf) begin
			sel_word.f.sign = cls.sign;
			sel_word.f.exp  = exp_w'(exp_max);
		end
		else if (cls.kind == kind_zero) begin
			sel_word.f.sign = cls.sign;            // Exp and frac stay zero
		end
		else if (prod.range == overflow) begin
			sel_word.f.sign = prod.sign;
			sel_word.f.exp  = exp_w'(exp_max);     // Saturate to inf
		end
		else if (prod.range == underflow) begin
			sel_word.f.sign = prod.sign;           // Signed zero
		end
		else begin
			sel_word.f.sign = prod.sign;
			sel_word.f.exp  = prod.exp;
			sel_word.f.frac = prod.frac;
		end
	end

	// Second stage, result holds while no operation arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result    <= '0;
			out_valid <= 1'b0;
		end
		else begin
			out_valid <= cls_valid;
			if (cls_valid) begin
				result <= sel_word;
			end
		end
	end

endmodule

`default_nettype wire

/* source/fp_mul_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  fp_mul_pkg::fp32_u a,
	input  fp_mul_pkg::fp32_u b,
	output logic              out_valid,
	output fp_mul_pkg::fp32_u result
);

	import fp_mul_pkg::*;

	// Stage 1 outputs
	fp_class_t cls;         // Special-value decision
	logic      cls_valid;   // Input strobe delayed by one
	fp_prod_t  prod;        // Normalized product with range

	// Corner cases, NaN / inf / zero
	fp_classify u_classify (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.cls       (cls),
		.cls_valid (cls_valid)
	);

	// Significand multiply and normalize
	// Works on the same operands in parallel
	fp_mant_mul u_mant_mul (
		.clk   (clk),
		.rst_n (rst_n),
		.a     (a),
		.b     (b),
		.prod  (prod)
	);

	// Stage 2, final word and output strobe
	fp_result_select u_result_select (
		.clk       (clk),
		.rst_n     (rst_n),
		.cls       (cls),
		.cls_valid (cls_valid),
		.prod      (prod),
		.out_valid (out_valid),
		.result    (result)
	);

endmodule

`default_nettype wire

/* tb/fp_mul_unit_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_unit_chk (
	input logic              clk,
	input logic              rst_n,
	input logic              in_valid,
	input fp_mul_pkg::fp32_u a,
	input fp_mul_pkg::fp32_u b,
	input logic              out_valid,
	input fp_mul_pkg::fp32_u result
);

	import fp_mul_pkg::*;

	logic nan_in;       // Accepted operand pair carries a NaN
	logic nan_out;      // Output word is a NaN

	assign nan_in  = in_valid && ((a.raw[mag_w-1:0] > mag_inf) || (b.raw[mag_w-1:0] > mag_inf));
	assign nan_out = out_valid && (result.f.exp == 8'hff) && (result.f.frac != '0);

	// Fixed two-cycle latency, no stalls possible
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##2 out_valid)
		else $error("out_valid missing two cycles after in_valid");

	// No strobe while held in reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// Datapath saturates to inf, so only a NaN operand can produce a NaN
	a_nan_source: assert property (@(posedge clk) disable iff (!rst_n)
		nan_out |-> $past(nan_in, 2))
		else $error("NaN result without a NaN operand");

endmodule

bind fp_mul_unit fp_mul_unit_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.a         (a),
	.b         (b),
	.out_valid (out_valid),
	.result    (result)
);

`default_nettype wire

/* tb/fp_mul_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_unit_tb;

	import fp_mul_pkg::*;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expected;
	} vec_t;

	localparam int n_random    = 200;
	localparam int max_wait    = 10;    // Cycles allowed per result
	localparam int reset_len   = 10;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	fp32_u       a;
	fp32_u       b;
	logic        out_valid;
	fp32_u       result;

	logic        valid_d1;              // in_valid seen at the last two edges
	logic        valid_d2;
	logic [31:0] rng;                   // xorshift state
	logic [31:0] last_result;           // Value result must hold between strobes
	vec_t        vectors[$];
	int          n_directed;

	fp_mul_unit dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	always #50 clk = ~clk;              // 100 ns period

	// Reference for out_valid two rising edges behind in_valid
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end
		else begin
			valid_d1 <= in_valid;
			valid_d2 <= valid_d1;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Behavioral binary32 product that truncates, flushes and saturates
	function automatic logic [31:0] model_mul(input logic [31:0] x, input logic [31:0] y);
		logic        s;
		int          ex;
		int          ey;
		int          e;
		logic [23:0] mx;
		logic [23:0] my;
		logic [47:0] m;
		s = x[31] ^ y[31];
		if (x[30:23] == 8'hff && x[22:0] != 23'h0) return x;    // NaN in x first
		if (y[30:23] == 8'hff && y[22:0] != 23'h0) return y;
		if (x[30:0] == 31'h7f800000) return {x[31], 31'h7f800000};
		if (y[30:0] == 31'h7f800000) return {y[31], 31'h7f800000};
		if (x[30:0] == 31'h0 || y[30:0] == 31'h0) return {s, 31'h0};
		ex = (x[30:23] == 8'h0) ? 1 : int'(x[30:23]);   // Subnormal counts as exponent 1
		ey = (y[30:23] == 8'h0) ? 1 : int'(y[30:23]);
		mx = {x[30:23] != 8'h0, x[22:0]};
		my = {y[30:23] != 8'h0, y[22:0]};
		m  = {24'h0, mx} * {24'h0, my};
		e  = ex + ey - 127;
		if (m[47]) begin
			m = m >> 1;
			e = e + 1;
		end
		else begin
			while (!m[46]) begin             // m is nonzero here so the loop ends
				m = m << 1;
				e = e - 1;
			end
		end
		if (e >= 255) return {s, 8'hff, 23'h0};
		if (e <= 0) return {s, 31'h0};
		return {s, e[7:0], m[45:23]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, expected);
			$display("Testbench failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic add_vector(input logic [31:0] va, input logic [31:0] vb,
		input logic [31:0] ve);
		vectors.push_back('{a: va, b: vb, expected: ve});
	endtask

	task automatic build_table();
		logic [31:0] ra;
		logic [31:0] rb;
		add_vector(32'h3fc00000, 32'h40000000, 32'h40400000);   // 1.5 * 2.0 = 3.0
		add_vector(32'h3f800000, 32'h40490fdb, 32'h40490fdb);   // 1.0 * pi
		add_vector(32'h3dcccccd, 32'h3f800000, 32'h3dcccccd);   // 0.1 * 1.0
		add_vector(32'hc0200000, 32'h40800000, 32'hc1200000);   // -2.5 * 4.0 = -10.0
		add_vector(32'h7fc12345, 32'h7f800001, 32'h7fc12345);   // a wins when both are NaN
		add_vector(32'h3f800000, 32'hffc00001, 32'hffc00001);   // NaN in b only
		add_vector(32'h7f800000, 32'h7fc00005, 32'h7fc00005);   // NaN in b beats inf in a
		add_vector(32'hff800000, 32'h40000000, 32'hff800000);   // -inf * 2.0
		add_vector(32'h7f800000, 32'hc0000000, 32'h7f800000);   // Sign of the inf operand
		add_vector(32'hc0000000, 32'h7f800000, 32'h7f800000);   // Inf in b keeps b's sign
		add_vector(32'h7f800000, 32'h80000000, 32'h7f800000);   // inf * -0 stays inf
		add_vector(32'h80000000, 32'h40400000, 32'h80000000);   // -0 * 3.0
		add_vector(32'hc0400000, 32'h80000000, 32'h00000000);   // -3.0 * -0 = +0
		add_vector(32'h7f000000, 32'h7f000000, 32'h7f800000);   // 2^127 squared overflows
		add_vector(32'h7f000000, 32'hff000000, 32'hff800000);
		add_vector(32'h00800000, 32'h00800000, 32'h00000000);   // 2^-126 squared flushes
		add_vector(32'h80800000, 32'h00800000, 32'h80000000);
		add_vector(32'h00000001, 32'h4b000000, 32'h00800000);   // 2^-149 * 2^23 = 2^-126
		n_directed = vectors.size();
		for (int i = 0; i < n_random; i++) begin
			rng = xorshift32(rng);
			ra  = rng;
			rng = xorshift32(rng);
			rb  = rng;
			add_vector(ra, rb, model_mul(ra, rb));
		end
	endtask

	// One operation per falling edge with idle gaps among the random part
	task automatic drive_vectors();
		int gap;
		repeat (3) @(negedge clk);          // Quiet cycles before the first strobe
		for (int i = 0; i < vectors.size(); i++) begin
			@(negedge clk);
			in_valid = 1'b1;
			a.raw    = vectors[i].a;
			b.raw    = vectors[i].b;
			rng      = xorshift32(rng);
			if (i >= n_directed && rng[2:0] == 3'd0) begin
				gap = int'(rng[4:3]) + 1;
				repeat (gap) begin
					@(negedge clk);
					in_valid = 1'b0;
					a.raw    = rng;             // Junk operands that must not reach result
					b.raw    = ~rng;
				end
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Waits for each result in issue order
	task automatic collect_results();
		int waited;
		for (int n = 0; n < vectors.size(); n++) begin
			waited = 0;
			do begin
				@(negedge clk);
				check_value("out_valid", {31'h0, out_valid}, {31'h0, valid_d2});
				if (!out_valid) begin
					check_value("result", result.raw, last_result);   // Holds when idle
				end
				waited++;
			end while (!out_valid && waited < max_wait);
			if (!out_valid) begin
				$display("Timeout: no out_valid for result %0d within %0d cycles", n, max_wait);
				$display("Testbench failed");
				$fatal(1, "Result %0d never arrived", n);
			end
			check_value("result", result.raw, vectors[n].expected);
			last_result = result.raw;
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		a           = '0;
		b           = '0;
		rng         = 32'd36;
		last_result = 32'h0;
		build_table();
		repeat (reset_len) begin
			@(negedge clk);
			check_value("out_valid", {31'h0, out_valid}, 32'h0);
		end
		rst_n = 1'b1;                       // Released on a falling edge
		fork
			drive_vectors();
			collect_results();
		join
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
source/fp_mul_pkg.sv
source/fp_classify.sv
source/fp_mant_mul.sv
source/fp_result_select.sv
source/fp_mul_unit.sv
tb/fp_mul_unit_chk.sv
tb/fp_mul_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = fp_mul_unit_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
